//--- src/tlu_pkg.sv
// shared widths, register map and types of the trigger controller
// the data-word views assume a 32-bit counter and a 16-bit timestamp
// bus addresses not listed here read as zero
`default_nettype none

package tlu_pkg;

localparam int bus_addr_width = 6;
localparam int bus_data_width = 8;
localparam int counter_width = 32;
localparam int ts_width = 16;

localparam logic [bus_data_width-1:0] tlu_version = 8'd11;

// register map, one byte per address
localparam logic [bus_addr_width-1:0] addr_reset_version = 6'd0; // write resets, read gives version
localparam logic [bus_addr_width-1:0] addr_conf = 6'd1; // bit 0 enable, bit 1 ts format
localparam logic [bus_addr_width-1:0] addr_trigger_select = 6'd2;
localparam logic [bus_addr_width-1:0] addr_veto_select = 6'd3;
localparam logic [bus_addr_width-1:0] addr_trigger_invert = 6'd4;
localparam logic [bus_addr_width-1:0] addr_counter_0 = 6'd5; // low byte, read snapshots the rest
localparam logic [bus_addr_width-1:0] addr_counter_1 = 6'd6;
localparam logic [bus_addr_width-1:0] addr_counter_2 = 6'd7;
localparam logic [bus_addr_width-1:0] addr_counter_3 = 6'd8; // write loads all four bytes
localparam logic [bus_addr_width-1:0] addr_counter_max_0 = 6'd9;
localparam logic [bus_addr_width-1:0] addr_counter_max_1 = 6'd10;
localparam logic [bus_addr_width-1:0] addr_counter_max_2 = 6'd11;
localparam logic [bus_addr_width-1:0] addr_counter_max_3 = 6'd12;
localparam logic [bus_addr_width-1:0] addr_lost_count = 6'd13;
localparam logic [bus_addr_width-1:0] addr_soft_trigger = 6'd14; // write only

typedef struct packed {
    logic [7:0] trigger_select;
    logic [7:0] veto_select;
    logic [7:0] trigger_invert;
} input_conf_t;

typedef struct packed {
    logic                     trigger_enable;
    logic                     ts_format; // 0 full count, 1 short count plus timestamp
    logic [counter_width-1:0] counter_max; // zero means no limit
} fsm_conf_t;

typedef struct packed {
    logic                     load;
    logic [counter_width-1:0] value;
} count_load_t;

typedef struct packed {
    logic                     marker; // always 1
    logic [counter_width-2:0] count;
} count_view_t;

typedef struct packed {
    logic                              marker; // always 1
    logic [counter_width-ts_width-2:0] count;
    logic [ts_width-1:0]               timestamp;
} stamp_view_t;

// one FIFO word, decoded by ts_format
typedef union packed {
    count_view_t count_view;
    stamp_view_t stamp_view;
} data_word_u;

typedef struct packed {
    logic       valid;
    data_word_u word;
} fifo_write_t;

endpackage

`default_nettype wire

//--- src/tlu_regs.sv
// byte-wide register block of the trigger controller
// bus_data_out is registered, valid the cycle after bus_rd and held otherwise
// soft_reset is decoded combinationally from a write to address 0
// read counter byte 0 first, it snapshots bytes 1 to 3 for a consistent read
// counter bytes 0 to 2 are staged, the write of byte 3 loads all four
`default_nettype none

module tlu_regs
    import tlu_pkg::*;
(
    input  wire                         BUS_CLK,
    input  wire                         RST_SYNC,
    input  wire [bus_addr_width-1:0]    bus_add,
    input  wire [bus_data_width-1:0]    bus_data_in,
    input  wire                         bus_rd,
    input  wire                         bus_wr,
    output logic [bus_data_width-1:0]   bus_data_out,
    input  wire [counter_width-1:0]     trigger_count,
    input  wire [bus_data_width-1:0]    lost_count,
    output input_conf_t                 input_conf,
    output fsm_conf_t                   fsm_conf,
    output count_load_t                 count_load,
    output logic                        soft_trigger,
    output logic                        soft_reset
);

localparam int upper_width = counter_width - bus_data_width;

logic                   regs_rst;
logic [upper_width-1:0] count_stage; // bytes 0 to 2 waiting for byte 3
logic [upper_width-1:0] count_snap; // bytes 1 to 3 taken on a byte 0 read

assign soft_reset = bus_wr && (bus_add == addr_reset_version);
assign regs_rst = RST_SYNC || soft_reset;

always_ff @(posedge BUS_CLK)
begin
    if (regs_rst)
    begin
        input_conf <= '0;
        fsm_conf <= '0;
        count_load <= '0;
        count_stage <= '0;
        soft_trigger <= 1'b0;
    end
    else
    begin
        count_load.load <= 1'b0; // strobes last one cycle
        soft_trigger <= 1'b0;
        if (bus_wr)
        begin
            case (bus_add)
                addr_conf:
                begin
                    fsm_conf.trigger_enable <= bus_data_in[0];
                    fsm_conf.ts_format <= bus_data_in[1];
                end
                addr_trigger_select: input_conf.trigger_select <= bus_data_in;
                addr_veto_select:    input_conf.veto_select <= bus_data_in;
                addr_trigger_invert: input_conf.trigger_invert <= bus_data_in;
                addr_counter_0:      count_stage[7:0] <= bus_data_in;
                addr_counter_1:      count_stage[15:8] <= bus_data_in;
                addr_counter_2:      count_stage[23:16] <= bus_data_in;
                addr_counter_3:
                begin
                    count_load.load <= 1'b1;
                    count_load.value <= {bus_data_in, count_stage};
                end
                addr_counter_max_0:  fsm_conf.counter_max[7:0] <= bus_data_in;
                addr_counter_max_1:  fsm_conf.counter_max[15:8] <= bus_data_in;
                addr_counter_max_2:  fsm_conf.counter_max[23:16] <= bus_data_in;
                addr_counter_max_3:  fsm_conf.counter_max[31:24] <= bus_data_in;
                addr_soft_trigger:   soft_trigger <= 1'b1;
                default: ;
            endcase
        end
    end
end

// read mux
always_ff @(posedge BUS_CLK)
begin
    if (regs_rst)
    begin
        bus_data_out <= '0;
        count_snap <= '0;
    end
    else if (bus_rd)
    begin
        case (bus_add)
            addr_reset_version:  bus_data_out <= tlu_version;
            addr_conf:
                bus_data_out <= {6'b0, fsm_conf.ts_format, fsm_conf.trigger_enable};
            addr_trigger_select: bus_data_out <= input_conf.trigger_select;
            addr_veto_select:    bus_data_out <= input_conf.veto_select;
            addr_trigger_invert: bus_data_out <= input_conf.trigger_invert;
            addr_counter_0:
            begin
                bus_data_out <= trigger_count[7:0];
                count_snap <= trigger_count[31:8]; // freeze upper bytes
            end
            addr_counter_1:      bus_data_out <= count_snap[7:0];
            addr_counter_2:      bus_data_out <= count_snap[15:8];
            addr_counter_3:      bus_data_out <= count_snap[23:16];
            addr_counter_max_0:  bus_data_out <= fsm_conf.counter_max[7:0];
            addr_counter_max_1:  bus_data_out <= fsm_conf.counter_max[15:8];
            addr_counter_max_2:  bus_data_out <= fsm_conf.counter_max[23:16];
            addr_counter_max_3:  bus_data_out <= fsm_conf.counter_max[31:24];
            addr_lost_count:     bus_data_out <= lost_count;
            default:             bus_data_out <= '0; // soft trigger and unused
        endcase
    end
end

endmodule

`default_nettype wire

//--- src/trigger_input.sv
// trigger and veto input conditioning
// trigger_width must not exceed the 8-bit select, veto and invert masks
// an input edge gives trigger_pulse three cycles later, veto lags two cycles
// an edge and a soft trigger in adjacent cycles merge into one pulse
`default_nettype none

module trigger_input
    import tlu_pkg::*;
#(
    parameter int trigger_width = 8
)
(
    input  wire                     BUS_CLK,
    input  wire                     RST_SYNC,
    input  wire [trigger_width-1:0] trigger,
    input  wire [trigger_width-1:0] trigger_veto,
    input  wire input_conf_t        input_conf,
    input  wire                     soft_trigger,
    output logic                    trigger_pulse,
    output logic                    veto
);

logic [trigger_width-1:0] trig_meta;
logic [trigger_width-1:0] trig_sync;
logic [trigger_width-1:0] veto_meta;
logic [trigger_width-1:0] veto_sync;
logic                     trig_hit;
logic                     trig_hit_q;

// two-stage synchronizers
always_ff @(posedge BUS_CLK)
begin
    if (RST_SYNC)
    begin
        trig_meta <= '0;
        trig_sync <= '0;
        veto_meta <= '0;
        veto_sync <= '0;
    end
    else
    begin
        trig_meta <= trigger;
        trig_sync <= trig_meta;
        veto_meta <= trigger_veto;
        veto_sync <= veto_meta;
    end
end

assign trig_hit = |((trig_sync ^ input_conf.trigger_invert[trigger_width-1:0])
                    & input_conf.trigger_select[trigger_width-1:0]);
assign veto = |(veto_sync & input_conf.veto_select[trigger_width-1:0]);

always_ff @(posedge BUS_CLK)
begin
    if (RST_SYNC)
    begin
        trig_hit_q <= 1'b0;
        trigger_pulse <= 1'b0;
    end
    else
    begin
        trig_hit_q <= trig_hit;
        // rising edge of the reduced trigger or a bus trigger
        trigger_pulse <= ((trig_hit & ~trig_hit_q) | soft_trigger) & ~trigger_pulse;
    end
end

a_single_pulse: assert property (@(posedge BUS_CLK) disable iff (RST_SYNC)
    trigger_pulse |=> !trigger_pulse);

endmodule

`default_nettype wire

//--- src/trigger_fsm.sv
// trigger accept logic with four-phase req/ack to the readout
// acceptance is the cycle after trigger_pulse, trigger_req follows one cycle later
// the next trigger is accepted only once trigger_ack is back low
// a counter load has priority over the increment of an accepted trigger
`default_nettype none

module trigger_fsm
    import tlu_pkg::*;
(
    input  wire                         BUS_CLK,
    input  wire                         RST_SYNC,
    input  wire                         trigger_pulse,
    input  wire                         veto,
    input  wire fsm_conf_t              fsm_conf,
    input  wire count_load_t            count_load,
    input  wire                         trigger_ack,
    output logic                        trigger_req,
    output logic                        busy,
    output logic                        trigger_enabled,
    output logic [counter_width-1:0]    trigger_count,
    output fifo_write_t                 fifo_write
);

typedef enum logic [1:0] {
    st_idle,
    st_req, // trigger_req high, waiting for ack
    st_release // req dropped, waiting for ack low
} state_t;

state_t              state;
logic                pulse_q;
logic                limit_reached;
logic                accept;
logic [ts_width-1:0] timestamp;

assign limit_reached = (fsm_conf.counter_max != '0) && (trigger_count >= fsm_conf.counter_max);
assign trigger_enabled = fsm_conf.trigger_enable && !limit_reached;
assign accept = (state == st_idle) && pulse_q && trigger_enabled && !veto && !trigger_ack;
assign busy = accept || (state != st_idle);
assign trigger_req = (state == st_req);

always_ff @(posedge BUS_CLK)
begin
    if (RST_SYNC)
        pulse_q <= 1'b0;
    else
        pulse_q <= trigger_pulse; // pulses outside idle are dropped here
end

always_ff @(posedge BUS_CLK)
begin
    if (RST_SYNC)
        state <= st_idle;
    else
    begin
        case (state)
            st_idle:    if (accept) state <= st_req;
            st_req:     if (trigger_ack) state <= st_release;
            st_release: if (!trigger_ack) state <= st_idle;
            default:    state <= st_idle;
        endcase
    end
end

always_ff @(posedge BUS_CLK)
begin
    if (RST_SYNC)
        trigger_count <= '0;
    else if (count_load.load)
        trigger_count <= count_load.value;
    else if (accept)
        trigger_count <= trigger_count + 1'b1;
end

// free-running, wraps
always_ff @(posedge BUS_CLK)
begin
    if (RST_SYNC)
        timestamp <= '0;
    else
        timestamp <= timestamp + 1'b1;
end

// word carries the count before the increment
always_comb
begin
    fifo_write.valid = accept;
    fifo_write.word = '0;
    if (fsm_conf.ts_format)
    begin
        fifo_write.word.stamp_view.marker = 1'b1;
        fifo_write.word.stamp_view.count = trigger_count[counter_width-ts_width-2:0];
        fifo_write.word.stamp_view.timestamp = timestamp;
    end
    else
    begin
        fifo_write.word.count_view.marker = 1'b1;
        fifo_write.word.count_view.count = trigger_count[counter_width-2:0];
    end
end

a_req_ack_low: assert property (@(posedge BUS_CLK) disable iff (RST_SYNC)
    $rose(trigger_req) |-> !trigger_ack);

a_write_leaves_idle: assert property (@(posedge BUS_CLK) disable iff (RST_SYNC)
    fifo_write.valid |=> ($past(state) == st_idle) && (state == st_req));

endmodule

`default_nettype wire

//--- src/event_fifo.sv
// show-ahead data FIFO for trigger words
// a word written in one cycle is at fifo_data with fifo_empty low the next
// writes to a full FIFO are dropped and counted, lost_count saturates at 255
// reading an empty FIFO does nothing, fifo_data is undefined while empty
`default_nettype none

module event_fifo
    import tlu_pkg::*;
#(
    parameter int fifo_depth = 8
)
(
    input  wire                          BUS_CLK,
    input  wire                          RST_SYNC,
    input  wire fifo_write_t             fifo_write,
    input  wire                          fifo_read,
    output logic [$bits(data_word_u)-1:0] fifo_data,
    output logic                         fifo_empty,
    output logic [bus_data_width-1:0]    lost_count
);

localparam int word_width = $bits(data_word_u);
localparam int ptr_width = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
localparam int occ_width = $clog2(fifo_depth + 1);

logic [word_width-1:0] mem [fifo_depth];
logic [ptr_width-1:0]  wr_ptr;
logic [ptr_width-1:0]  rd_ptr;
logic [occ_width-1:0]  occupancy;
logic                  full;
logic                  do_write;
logic                  do_read;

function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] ptr);
    if (ptr == ptr_width'(fifo_depth - 1))
        return '0;
    return ptr + 1'b1;
endfunction

assign full = (occupancy == occ_width'(fifo_depth));
assign fifo_empty = (occupancy == '0);
assign do_write = fifo_write.valid && !full;
assign do_read = fifo_read && !fifo_empty;
assign fifo_data = mem[rd_ptr]; // head is always visible

always_ff @(posedge BUS_CLK)
begin
    if (do_write)
        mem[wr_ptr] <= fifo_write.word;
end

always_ff @(posedge BUS_CLK)
begin
    if (RST_SYNC)
    begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        occupancy <= '0;
        lost_count <= '0;
    end
    else
    begin
        if (do_write)
            wr_ptr <= next_ptr(wr_ptr);
        if (do_read)
            rd_ptr <= next_ptr(rd_ptr);
        case ({do_write, do_read})
            2'b10:   occupancy <= occupancy + 1'b1;
            2'b01:   occupancy <= occupancy - 1'b1;
            default: ; // both or neither
        endcase
        if (fifo_write.valid && full && (lost_count != '1))
            lost_count <= lost_count + 1'b1;
    end
end

a_occupancy: assert property (@(posedge BUS_CLK) disable iff (RST_SYNC)
    occupancy <= occ_width'(fifo_depth));

endmodule

`default_nettype wire

//--- src/tlu_controller.sv
// single-clock trigger controller top level
// everything runs on BUS_CLK, trigger and veto inputs may be asynchronous
// trigger_width is at most 8, fifo_depth at least 2
// a bus write to address 0 resets the whole core like RST_SYNC
`default_nettype none

module tlu_controller
    import tlu_pkg::*;
#(
    parameter int trigger_width = 8,
    parameter int fifo_depth = 8
)
(
    input  wire                           BUS_CLK,
    input  wire                           RST_SYNC,
    input  wire [bus_addr_width-1:0]      bus_add,
    input  wire [bus_data_width-1:0]      bus_data_in,
    input  wire                           bus_rd,
    input  wire                           bus_wr,
    output wire [bus_data_width-1:0]      bus_data_out,
    input  wire [trigger_width-1:0]       trigger,
    input  wire [trigger_width-1:0]       trigger_veto,
    input  wire                           trigger_ack,
    output wire                           trigger_req,
    output wire                           busy,
    output wire                           trigger_enabled,
    input  wire                           fifo_read,
    output wire [$bits(data_word_u)-1:0]  fifo_data,
    output wire                           fifo_empty
);

input_conf_t                 input_conf;
fsm_conf_t                   fsm_conf;
count_load_t                 count_load;
fifo_write_t                 fifo_write;
logic [counter_width-1:0]    trigger_count;
logic [bus_data_width-1:0]   lost_count;
logic                        soft_trigger;
logic                        soft_reset;
logic                        core_rst;
logic                        trigger_pulse;
logic                        veto;

assign core_rst = RST_SYNC || soft_reset;

tlu_regs u_tlu_regs (
    .BUS_CLK(BUS_CLK), .RST_SYNC(RST_SYNC),
    .bus_add(bus_add), .bus_data_in(bus_data_in), .bus_rd(bus_rd), .bus_wr(bus_wr),
    .bus_data_out(bus_data_out), .trigger_count(trigger_count), .lost_count(lost_count),
    .input_conf(input_conf), .fsm_conf(fsm_conf), .count_load(count_load),
    .soft_trigger(soft_trigger), .soft_reset(soft_reset)
);

trigger_input #(.trigger_width(trigger_width)) u_trigger_input (
    .BUS_CLK(BUS_CLK), .RST_SYNC(core_rst),
    .trigger(trigger), .trigger_veto(trigger_veto), .input_conf(input_conf),
    .soft_trigger(soft_trigger), .trigger_pulse(trigger_pulse), .veto(veto)
);

trigger_fsm u_trigger_fsm (
    .BUS_CLK(BUS_CLK), .RST_SYNC(core_rst),
    .trigger_pulse(trigger_pulse), .veto(veto), .fsm_conf(fsm_conf), .count_load(count_load),
    .trigger_ack(trigger_ack), .trigger_req(trigger_req), .busy(busy),
    .trigger_enabled(trigger_enabled), .trigger_count(trigger_count), .fifo_write(fifo_write)
);

event_fifo #(.fifo_depth(fifo_depth)) u_event_fifo (
    .BUS_CLK(BUS_CLK), .RST_SYNC(core_rst),
    .fifo_write(fifo_write), .fifo_read(fifo_read), .fifo_data(fifo_data),
    .fifo_empty(fifo_empty), .lost_count(lost_count)
);

endmodule

`default_nettype wire

//--- verif/tb_tlu_controller.sv
// testbench for the trigger controller, steps from a table applied in order
// the readout responder acks trigger_req after a random 1 to 8 cycles
// expected FIFO words come from a model queue that mirrors the eight-deep FIFO
// stops at the first failed check
`default_nettype none

module tb_tlu_controller
    import tlu_pkg::*;
();

timeunit 1ns;
timeprecision 1ps;

localparam int trigger_width = 8;
localparam int fifo_depth = 8;
localparam int reset_cycles = 10;

typedef enum logic [3:0] {
    op_write,   // bus write, model follows
    op_read,    // bus read, data is the expected byte
    op_pulse,   // raise trigger bits for three cycles
    op_level,   // new resting level of the trigger inputs
    op_veto,    // new veto input level
    op_soft,    // soft trigger through the bus
    op_word,    // pop one FIFO word and compare with the model
    op_empty,
    op_idle,    // reset state of the flags
    op_enabled, // data[0] is the expected trigger_enabled
    op_count    // four-byte counter read against the model
} op_t;

typedef struct packed {
    op_t                       op;
    logic [bus_addr_width-1:0] addr;
    logic [7:0]                data;
    logic                      trig; // step should give one accepted trigger
} step_t;

logic                      BUS_CLK;
logic                      RST_SYNC;
logic [bus_addr_width-1:0] bus_add;
logic [bus_data_width-1:0] bus_data_in;
logic                      bus_rd;
logic                      bus_wr;
logic [bus_data_width-1:0] bus_data_out;
logic [trigger_width-1:0]  trigger;
logic [trigger_width-1:0]  trigger_veto;
logic                      trigger_ack = 1'b0;
logic                      trigger_req;
logic                      busy;
logic                      trigger_enabled;
logic                      fifo_read;
logic [31:0]               fifo_data;
logic                      fifo_empty;

step_t                     steps[$];
logic [32:0]               expected_words[$]; // {ts_format, count}
logic [trigger_width-1:0]  trig_level;
logic [31:0]               model_count;
logic [23:0]               model_stage;
logic                      model_fmt;
logic                      have_ts;
logic [15:0]               last_ts;
int                        seed = 32'h339a_5175;
int                        cycle_count = 0;
int                        timeout_limit = 0;

tlu_controller #(.trigger_width(trigger_width), .fifo_depth(fifo_depth)) u_tlu_controller (
    .BUS_CLK(BUS_CLK), .RST_SYNC(RST_SYNC),
    .bus_add(bus_add), .bus_data_in(bus_data_in), .bus_rd(bus_rd), .bus_wr(bus_wr),
    .bus_data_out(bus_data_out), .trigger(trigger), .trigger_veto(trigger_veto),
    .trigger_ack(trigger_ack), .trigger_req(trigger_req), .busy(busy),
    .trigger_enabled(trigger_enabled), .fifo_read(fifo_read), .fifo_data(fifo_data),
    .fifo_empty(fifo_empty)
);

initial
begin
    BUS_CLK = 1'b0;
    forever #10 BUS_CLK = ~BUS_CLK;
end

always @(posedge BUS_CLK)
begin
    cycle_count <= cycle_count + 1;
    if (timeout_limit != 0 && cycle_count >= timeout_limit)
        fail_run($sformatf("Timeout: the run did not finish within %0d cycles", timeout_limit));
end

// readout side of the four-phase handshake
always
begin : readout_responder
    int unsigned ack_delay;
    @(posedge BUS_CLK);
    #2;
    if (trigger_req === 1'b1 && trigger_ack === 1'b0)
    begin
        ack_delay = 1 + ($unsigned($random(seed)) % 8);
        repeat (ack_delay)
            @(posedge BUS_CLK);
        #2;
        trigger_ack = 1'b1;
        while (trigger_req === 1'b1)
        begin
            @(posedge BUS_CLK);
            #2;
        end
        trigger_ack = 1'b0;
    end
end

task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Something failed");
    $fatal(1, "stopped at the first error");
endtask

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] expected);
    assert (got === expected)
    else
        fail_run($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, expected));
endtask

task automatic next_cycle();
    @(posedge BUS_CLK);
    #2; // inputs change just after the edge
endtask

task automatic bus_write(input logic [bus_addr_width-1:0] addr, input logic [7:0] data);
    bus_add = addr;
    bus_data_in = data;
    bus_wr = 1'b1;
    next_cycle();
    bus_wr = 1'b0;
endtask

task automatic bus_read(input logic [bus_addr_width-1:0] addr, output logic [7:0] data);
    bus_add = addr;
    bus_rd = 1'b1;
    next_cycle();
    bus_rd = 1'b0;
    data = bus_data_out; // registered, valid now
endtask

task automatic clear_model();
    model_count = '0;
    model_stage = '0;
    model_fmt = 1'b0;
    have_ts = 1'b0;
    last_ts = '0;
    expected_words.delete();
endtask

task automatic update_model(input logic [bus_addr_width-1:0] addr, input logic [7:0] data);
    case (addr)
        addr_reset_version: clear_model();
        addr_conf:          model_fmt = data[1];
        addr_counter_0:     model_stage[7:0] = data;
        addr_counter_1:     model_stage[15:8] = data;
        addr_counter_2:     model_stage[23:16] = data;
        addr_counter_3:     model_count = {data, model_stage};
        default: ;
    endcase
endtask

// accepted trigger, word kept only while the FIFO has room
task automatic await_trigger(input logic expected);
    if (expected)
    begin
        while (trigger_req !== 1'b1)
            next_cycle();
        while (busy !== 1'b0)
            next_cycle();
        if (expected_words.size() < fifo_depth)
            expected_words.push_back({model_fmt, model_count});
        model_count = model_count + 1;
    end
    else
    begin
        repeat (8)
        begin
            next_cycle();
            check_value("trigger_req", 32'(trigger_req), 32'h0);
            check_value("busy", 32'(busy), 32'h0);
        end
    end
endtask

task automatic check_word();
    logic [32:0] entry;
    assert (expected_words.size() > 0)
    else
        fail_run("The table expects a FIFO word but the model holds none");
    entry = expected_words.pop_front();
    check_value("fifo_empty", 32'(fifo_empty), 32'h0);
    if (entry[32])
    begin
        // marker, 15-bit count, 16-bit timestamp
        check_value("fifo_data[31:16]", 32'(fifo_data[31:16]), 32'({1'b1, entry[14:0]}));
        if (have_ts)
        begin
            assert (fifo_data[15:0] > last_ts)
            else
                fail_run("The timestamp did not increase from one word to the next");
        end
        have_ts = 1'b1;
        last_ts = fifo_data[15:0];
    end
    else
        check_value("fifo_data", fifo_data, {1'b1, entry[30:0]});
    fifo_read = 1'b1;
    next_cycle();
    fifo_read = 1'b0;
endtask

task automatic check_count();
    logic [7:0]  b0;
    logic [7:0]  b1;
    logic [7:0]  b2;
    logic [7:0]  b3;
    next_cycle(); // a counter load reaches the FSM one cycle after its write
    bus_read(addr_counter_0, b0);
    bus_read(addr_counter_1, b1);
    bus_read(addr_counter_2, b2);
    bus_read(addr_counter_3, b3);
    check_value("trigger_count", {b3, b2, b1, b0}, model_count);
endtask

task automatic run_step(input step_t s);
    logic [7:0] rd_data;
    case (s.op)
        op_write:
        begin
            bus_write(s.addr, s.data);
            update_model(s.addr, s.data);
        end
        op_read:
        begin
            bus_read(s.addr, rd_data);
            check_value("bus_data_out", 32'(rd_data), 32'(s.data));
        end
        op_pulse:
        begin
            trigger = trig_level | s.data;
            repeat (3)
                next_cycle();
            trigger = trig_level;
            await_trigger(s.trig);
        end
        op_level:
        begin
            trig_level = s.data;
            trigger = s.data;
            await_trigger(s.trig);
        end
        op_veto:
        begin
            trigger_veto = s.data;
            repeat (4)
                next_cycle();
        end
        op_soft:
        begin
            bus_write(addr_soft_trigger, 8'h00);
            await_trigger(s.trig);
        end
        op_word:  check_word();
        op_empty: check_value("fifo_empty", 32'(fifo_empty), 32'h1);
        op_idle:
        begin
            check_value("fifo_empty", 32'(fifo_empty), 32'h1);
            check_value("trigger_req", 32'(trigger_req), 32'h0);
            check_value("trigger_enabled", 32'(trigger_enabled), 32'h0);
            check_value("busy", 32'(busy), 32'h0);
        end
        op_enabled: check_value("trigger_enabled", 32'(trigger_enabled), 32'(s.data[0]));
        op_count:   check_count();
        default:    fail_run("Unknown step in the stimulus table");
    endcase
endtask

task automatic add_step(input op_t op, input logic [bus_addr_width-1:0] addr,
                        input logic [7:0] data, input logic trig);
    steps.push_back({op, addr, data, trig});
endtask

task automatic add_reset_checks();
    add_step(op_read, addr_reset_version, tlu_version, 1'b0);
    add_step(op_idle, '0, 8'h00, 1'b0);
    add_step(op_read, addr_conf, 8'h00, 1'b0);
    add_step(op_read, addr_trigger_select, 8'h00, 1'b0);
    add_step(op_read, addr_veto_select, 8'h00, 1'b0);
    add_step(op_read, addr_trigger_invert, 8'h00, 1'b0);
    add_step(op_read, addr_lost_count, 8'h00, 1'b0);
    add_step(op_count, '0, 8'h00, 1'b0);
endtask

task automatic build_table();
    // reset values and register read-back, triggers kept disabled
    add_reset_checks();
    add_step(op_write, addr_conf, 8'h02, 1'b0);
    add_step(op_read, addr_conf, 8'h02, 1'b0);
    add_step(op_write, addr_trigger_select, 8'ha5, 1'b0);
    add_step(op_read, addr_trigger_select, 8'ha5, 1'b0);
    add_step(op_write, addr_veto_select, 8'h5a, 1'b0);
    add_step(op_read, addr_veto_select, 8'h5a, 1'b0);
    add_step(op_write, addr_trigger_invert, 8'h3c, 1'b0);
    add_step(op_read, addr_trigger_invert, 8'h3c, 1'b0);
    add_step(op_write, addr_trigger_invert, 8'h00, 1'b0);
    add_step(op_write, addr_trigger_select, 8'h00, 1'b0);
    add_step(op_write, addr_veto_select, 8'h00, 1'b0);
    add_step(op_write, addr_conf, 8'h00, 1'b0);
    // select mask and inverted input
    add_step(op_write, addr_trigger_select, 8'h04, 1'b0);
    add_step(op_write, addr_conf, 8'h01, 1'b0);
    add_step(op_enabled, '0, 8'h01, 1'b0);
    add_step(op_pulse, '0, 8'h04, 1'b1);
    add_step(op_word, '0, 8'h00, 1'b0);
    add_step(op_count, '0, 8'h00, 1'b0);
    add_step(op_pulse, '0, 8'h20, 1'b0);
    add_step(op_empty, '0, 8'h00, 1'b0);
    add_step(op_level, '0, 8'h08, 1'b0);
    add_step(op_write, addr_trigger_invert, 8'h08, 1'b0);
    add_step(op_write, addr_trigger_select, 8'h08, 1'b0);
    add_step(op_level, '0, 8'h00, 1'b1);
    add_step(op_word, '0, 8'h00, 1'b0);
    add_step(op_level, '0, 8'h08, 1'b0);
    add_step(op_write, addr_trigger_select, 8'h04, 1'b0);
    add_step(op_write, addr_trigger_invert, 8'h00, 1'b0);
    add_step(op_level, '0, 8'h00, 1'b0);
    // veto blocks input and soft triggers
    add_step(op_write, addr_veto_select, 8'h01, 1'b0);
    add_step(op_veto, '0, 8'h01, 1'b0);
    add_step(op_pulse, '0, 8'h04, 1'b0);
    add_step(op_soft, '0, 8'h00, 1'b0);
    add_step(op_empty, '0, 8'h00, 1'b0);
    add_step(op_veto, '0, 8'h00, 1'b0);
    add_step(op_soft, '0, 8'h00, 1'b1);
    add_step(op_word, '0, 8'h00, 1'b0);
    add_step(op_write, addr_veto_select, 8'h00, 1'b0);
    // counter load 5, limit 7
    add_step(op_write, addr_counter_0, 8'h05, 1'b0);
    add_step(op_write, addr_counter_1, 8'h00, 1'b0);
    add_step(op_write, addr_counter_2, 8'h00, 1'b0);
    add_step(op_write, addr_counter_3, 8'h00, 1'b0);
    add_step(op_count, '0, 8'h00, 1'b0);
    add_step(op_write, addr_counter_max_0, 8'h07, 1'b0);
    add_step(op_pulse, '0, 8'h04, 1'b1);
    add_step(op_pulse, '0, 8'h04, 1'b1);
    add_step(op_enabled, '0, 8'h00, 1'b0);
    add_step(op_pulse, '0, 8'h04, 1'b0);
    add_step(op_word, '0, 8'h00, 1'b0);
    add_step(op_word, '0, 8'h00, 1'b0);
    add_step(op_empty, '0, 8'h00, 1'b0);
    add_step(op_count, '0, 8'h00, 1'b0);
    add_step(op_write, addr_counter_max_0, 8'h00, 1'b0);
    add_step(op_enabled, '0, 8'h01, 1'b0);
    // timestamp format
    add_step(op_write, addr_conf, 8'h03, 1'b0);
    for (int i = 0; i < 3; i++)
        add_step(op_pulse, '0, 8'h04, 1'b1);
    for (int i = 0; i < 3; i++)
        add_step(op_word, '0, 8'h00, 1'b0);
    add_step(op_empty, '0, 8'h00, 1'b0);
    add_step(op_write, addr_conf, 8'h01, 1'b0);
    // overflow, then soft reset
    for (int i = 0; i < 10; i++)
        add_step(op_pulse, '0, 8'h04, 1'b1);
    for (int i = 0; i < fifo_depth; i++)
        add_step(op_word, '0, 8'h00, 1'b0);
    add_step(op_empty, '0, 8'h00, 1'b0);
    add_step(op_read, addr_lost_count, 8'h02, 1'b0);
    add_step(op_write, addr_reset_version, 8'h00, 1'b0);
    add_reset_checks();
endtask

initial
begin
    RST_SYNC = 1'b1;
    bus_add = '0;
    bus_data_in = '0;
    bus_rd = 1'b0;
    bus_wr = 1'b0;
    trigger = '0;
    trigger_veto = '0;
    fifo_read = 1'b0;
    trig_level = '0;
    clear_model();
    build_table();
    timeout_limit = steps.size() * 200 + reset_cycles;
    repeat (reset_cycles)
        @(posedge BUS_CLK);
    #2;
    RST_SYNC = 1'b0;
    foreach (steps[i])
        run_step(steps[i]);
    $display("Everything OK");
    $finish;
end

endmodule

`default_nettype wire

//--- project.f
src/tlu_pkg.sv
src/tlu_regs.sv
src/trigger_input.sv
src/trigger_fsm.sv
src/event_fifo.sv
src/tlu_controller.sv
verif/tb_tlu_controller.sv

//--- run.sh
#!/bin/sh
# build and run the trigger controller testbench with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_tlu_controller \
    -f project.f -o tb_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_sim > "$log" 2>&1
sim_status=$?
cat "$log"

if grep -q "Something failed" "$log"; then
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi
exit 0
